// File: sources.f
+incdir+include
design/rapid_pkg.sv
design/stage_if.sv
design/decoder_logic.sv
design/register_file.sv
design/execute_unit.sv
design/issue_control.sv
design/rapid_core_top.sv
verif/tb_rapid_core.sv

// File: Bender.yml
package:
  name: rapid_core

export_include_dirs:
  - include

sources:
  - files:
      - design/rapid_pkg.sv
      - design/stage_if.sv
      - design/decoder_logic.sv
      - design/register_file.sv
      - design/execute_unit.sv
      - design/issue_control.sv
      - design/rapid_core_top.sv
  - target: test
    files:
      - verif/tb_rapid_core.sv

// File: verif/tb_rapid_core.sv
`include "rapid_cfg.svh"

module tb_rapid_core;
    timeunit 1ns;
    timeprecision 100ps;
    import rapid_pkg::*;

    localparam int         num_instr  = 152;
    localparam logic [6:0] opc_lui    = 7'b0110111;
    localparam logic [6:0] opc_auipc  = 7'b0010111;
    localparam logic [6:0] opc_jal    = 7'b1101111;
    localparam logic [6:0] opc_jalr   = 7'b1100111;
    localparam logic [6:0] opc_branch = 7'b1100011;
    localparam logic [6:0] opc_load   = 7'b0000011;
    localparam logic [6:0] opc_store  = 7'b0100011;
    localparam logic [6:0] opc_op_imm = 7'b0010011;
    localparam logic [6:0] opc_op     = 7'b0110011;

    typedef struct {
        logic      we;
        reg_addr_t rd;
        word_t     data;
        logic      has_data;
        word_t     next_pc;
    } expect_t;

    logic      clk;
    logic      reset;
    logic      instr_req;
    word_t     instr;
    logic      instr_ack;
    word_t     retire_pc;
    logic      rd_we;
    reg_addr_t rd_addr;
    word_t     rd_data;
    word_t     next_pc;

    word_t     model_regs [`RAPID_NUM_REGS];
    word_t     model_pc;
    word_t     lfsr_state;
    word_t     pending [$];
    string     test_name;
    int        num_checked;
    logic      ack_prev = 1'b0;

    rapid_core_top DUT
    (
        .i_clk       (clk),
        .i_reset     (reset),
        .i_instr_req (instr_req),
        .i_instr     (instr),
        .o_instr_ack (instr_ack),
        .o_retire_pc (retire_pc),
        .o_rd_we     (rd_we),
        .o_rd_addr   (rd_addr),
        .o_rd_data   (rd_data),
        .o_next_pc   (next_pc)
    );

    initial
    begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Each handshake needs well under ten cycles
    initial
    begin
        #(num_instr * 10 * 100);
        abort_run("watchdog expired before all instructions retired");
    end

    //////////////////////////////////////////////////
    // Failure reporting and compare tasks
    //////////////////////////////////////////////////

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("*** TEST FAILED ***");
        $fatal(1, "simulation stopped on first error");
    endtask

    task automatic check_word(input string what, input word_t exp, input word_t act);
        if (act !== exp)
            abort_run($sformatf("FAIL %s %s: expected %h, actual %h", test_name, what, exp, act));
    endtask

    task automatic check_reg_addr(input string what, input reg_addr_t exp, input reg_addr_t act);
        if (act !== exp)
            abort_run($sformatf("FAIL %s %s: expected %0d, actual %0d", test_name, what, exp, act));
    endtask

    task automatic check_flag(input string what, input logic exp, input logic act);
        if (act !== exp)
            abort_run($sformatf("FAIL %s %s: expected %b, actual %b", test_name, what, exp, act));
    endtask

    //////////////////////////////////////////////////
    // Random source and instruction encoders
    //////////////////////////////////////////////////

    function automatic logic lfsr_bit();
        logic out;
        out        = lfsr_state[0];
        lfsr_state = lfsr_state >> 1;
        if (out)
            lfsr_state = lfsr_state ^ 32'hB4BC_D35C;
        return out;
    endfunction

    function automatic word_t rand_bits(input int n);
        word_t v;
        v = '0;
        for (int i = 0; i < n; i++)
        begin
            v = {v[30:0], lfsr_bit()};
        end
        return v;
    endfunction

    function automatic reg_addr_t rand_reg();
        return reg_addr_t'(rand_bits(5));
    endfunction

    function automatic word_t enc_i(input word_t imm, input reg_addr_t rs1, input logic [2:0] f3,
                                    input reg_addr_t rd, input logic [6:0] opc);
        return {imm[11:0], rs1, f3, rd, opc};
    endfunction

    function automatic word_t enc_r(input logic [6:0] f7, input reg_addr_t rs2,
                                    input reg_addr_t rs1, input logic [2:0] f3, input reg_addr_t rd);
        return {f7, rs2, rs1, f3, rd, opc_op};
    endfunction

    function automatic word_t enc_s(input word_t imm, input reg_addr_t rs2, input reg_addr_t rs1,
                                    input logic [2:0] f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], opc_store};
    endfunction

    function automatic word_t enc_b(input word_t imm, input reg_addr_t rs2, input reg_addr_t rs1,
                                    input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], opc_branch};
    endfunction

    function automatic word_t enc_u(input word_t imm, input reg_addr_t rd, input logic [6:0] opc);
        return {imm[19:0], rd, opc};
    endfunction

    function automatic word_t enc_j(input word_t imm, input reg_addr_t rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, opc_jal};
    endfunction

    //////////////////////////////////////////////////
    // Reference model
    //////////////////////////////////////////////////

    function automatic word_t alu_ref(input logic [2:0] f3, input logic alt,
                                      input word_t a, input word_t b);
        word_t r;
        case (f3)
            3'd0:    r = alt ? a - b : a + b;
            3'd1:    r = a << b[4:0];
            3'd2:    r = word_t'($signed(a) < $signed(b));
            3'd3:    r = word_t'(a < b);
            3'd4:    r = a ^ b;
            3'd5:
            begin
                if (alt)
                    r = $signed(a) >>> b[4:0];
                else
                    r = a >> b[4:0];
            end
            3'd6:    r = a | b;
            default: r = a & b;
        endcase
        return r;
    endfunction

    function automatic expect_t predict(input word_t ins, input word_t pc);
        expect_t    e;
        word_t      a;
        word_t      b;
        word_t      imm_i;
        word_t      imm_s;
        word_t      imm_b;
        word_t      imm_j;
        word_t      imm_u;
        logic [2:0] f3;
        logic       taken;
        a      = model_regs[ins[19:15]];
        b      = model_regs[ins[24:20]];
        f3     = ins[14:12];
        imm_i  = {{20{ins[31]}}, ins[31:20]};
        imm_s  = {{20{ins[31]}}, ins[31:25], ins[11:7]};
        imm_b  = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
        imm_j  = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
        imm_u  = {ins[31:12], 12'b0};
        e.we       = 1'b0;
        e.rd       = ins[11:7];
        e.data     = '0;
        e.has_data = 1'b0;
        e.next_pc  = pc + 4;
        case (ins[6:0])
            opc_lui:   {e.we, e.data} = {1'b1, imm_u};
            opc_auipc: {e.we, e.data} = {1'b1, pc + imm_u};
            opc_jal:
            begin
                {e.we, e.data} = {1'b1, pc + 4};
                e.next_pc      = pc + imm_j;
            end
            opc_jalr:
            begin
                {e.we, e.data} = {1'b1, pc + 4};
                e.next_pc      = (a + imm_i) & ~word_t'(1);
            end
            opc_branch:
            begin
                case (f3)
                    3'd0:    taken = (a == b);
                    3'd1:    taken = (a != b);
                    3'd4:    taken = ($signed(a) < $signed(b));
                    3'd5:    taken = ($signed(a) >= $signed(b));
                    3'd6:    taken = (a < b);
                    3'd7:    taken = (a >= b);
                    default: taken = 1'b0;
                endcase
                if (taken)
                    e.next_pc = pc + imm_b;
            end
            // Effective address only, nothing is written back
            opc_load:  {e.has_data, e.data} = {1'b1, a + imm_i};
            opc_store: {e.has_data, e.data} = {1'b1, a + imm_s};
            opc_op_imm:
                {e.we, e.data} = {1'b1, alu_ref(f3, ins[30] && (f3 == 3'd5), a, imm_i)};
            opc_op:    {e.we, e.data} = {1'b1, alu_ref(f3, ins[30], a, b)};
            default:   e.we = 1'b0;
        endcase
        e.has_data = e.has_data || e.we;
        return e;
    endfunction

    task automatic check_retire();
        word_t   ins;
        expect_t e;
        if (pending.size() == 0)
            abort_run("ack rose with no instruction outstanding");
        else
        begin
            ins = pending.pop_front();
            e   = predict(ins, model_pc);
            check_word("retire pc", model_pc, retire_pc);
            check_flag("rd_we", e.we, rd_we);
            check_reg_addr("rd_addr", e.rd, rd_addr);
            if (e.has_data)
                check_word("rd_data", e.data, rd_data);
            check_word("next pc", e.next_pc, next_pc);
            if (e.we && (e.rd != '0))
                model_regs[e.rd] = e.data;
            model_pc = e.next_pc;
            num_checked++;
        end
    endtask

    // Compare on every rising ack, sampled mid-cycle
    always @(negedge clk)
    begin
        if (instr_ack && !ack_prev)
            check_retire();
        ack_prev = instr_ack;
    end

    //////////////////////////////////////////////////
    // Four-phase driver
    //////////////////////////////////////////////////

    task automatic issue_instr(input word_t ins);
        int        edges;
        int        hold;
        word_t     held_data;
        word_t     held_next;
        word_t     held_pc;
        reg_addr_t held_rd;
        logic      held_we;
        hold = int'(rand_bits(2));
        @(posedge clk);
        instr_req <= 1'b1;
        instr     <= ins;
        pending.push_back(ins);
        edges = 0;
        do
        begin
            @(negedge clk);
            edges++;
        end
        while (!instr_ack);
        // The first negedge comes before the edge that samples req
        check_word("ack latency", word_t'(2), word_t'(edges - 1));
        held_data = rd_data;
        held_next = next_pc;
        held_pc   = retire_pc;
        held_rd   = rd_addr;
        held_we   = rd_we;
        repeat (hold)
        begin
            @(negedge clk);
            check_flag("ack under back-pressure", 1'b1, instr_ack);
            check_word("held rd_data", held_data, rd_data);
            check_word("held next pc", held_next, next_pc);
            check_word("held retire pc", held_pc, retire_pc);
            check_reg_addr("held rd_addr", held_rd, rd_addr);
            check_flag("held rd_we", held_we, rd_we);
        end
        @(posedge clk);
        instr_req <= 1'b0;
        @(negedge clk);
        check_flag("ack before req sampled low", 1'b1, instr_ack);
        @(negedge clk);
        check_flag("ack after req sampled low", 1'b0, instr_ack);
    endtask

    //////////////////////////////////////////////////
    // Test sequence
    //////////////////////////////////////////////////

    initial
    begin
        word_t      v;
        reg_addr_t  r;
        logic [2:0] f3;
        logic       alt;
        reset       = 1'b1;
        instr_req   = 1'b0;
        instr       = '0;
        lfsr_state  = 32'd73;
        model_pc    = `RAPID_RESET_PC;
        num_checked = 0;
        for (int k = 0; k < `RAPID_NUM_REGS; k++)
        begin
            model_regs[k] = '0;
        end

        test_name = "reset";
        repeat (4) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        check_flag("ack", 1'b0, instr_ack);
        check_flag("rd_we", 1'b0, rd_we);
        for (int k = 0; k < 32; k++)
        begin
            issue_instr(enc_i('0, reg_addr_t'(k), 3'd0, reg_addr_t'(k), opc_op_imm));
        end

        // LUI then ADDI into the same register
        test_name = "seed";
        for (int i = 0; i < 8; i++)
        begin
            r = rand_reg();
            issue_instr(enc_u(rand_bits(20), r, opc_lui));
            issue_instr(enc_i(rand_bits(12), r, 3'd0, r, opc_op_imm));
        end

        // Counter bits pick funct3, register or immediate, and the alternate op
        test_name = "alu";
        for (int i = 0; i < 48; i++)
        begin
            f3  = 3'(i);
            alt = i[4];
            if (i[3])
                issue_instr(enc_r((alt && (f3 == 3'd0 || f3 == 3'd5)) ? 7'h20 : 7'h00,
                                  rand_reg(), rand_reg(), f3, rand_reg()));
            else
            begin
                v = rand_bits(12);
                if (f3 == 3'd1)
                    v[11:5] = 7'h00;
                if (f3 == 3'd5)
                    v[11:5] = alt ? 7'h20 : 7'h00;
                issue_instr(enc_i(v, rand_reg(), f3, rand_reg(), opc_op_imm));
            end
        end

        // LUI and AUIPC alternate
        test_name = "upper";
        for (int i = 0; i < 8; i++)
        begin
            issue_instr(enc_u(rand_bits(20), rand_reg(), (i % 2 == 0) ? opc_lui : opc_auipc));
        end

        test_name = "branch";
        issue_instr(enc_b(word_t'(8), '0, '0, 3'd0));
        issue_instr(enc_b(word_t'(12), '0, '0, 3'd1));
        for (int i = 0; i < 12; i++)
        begin
            f3 = ((i % 6) < 2) ? 3'(i % 6) : 3'(i % 6 + 2);
            issue_instr(enc_b(rand_bits(11) << 2, rand_reg(), rand_reg(), f3));
        end

        test_name = "jump";
        for (int i = 0; i < 6; i++)
        begin
            issue_instr(enc_j(rand_bits(19) << 2, rand_reg()));
        end
        // Odd JALR offset exercises the bit 0 clear
        for (int i = 0; i < 6; i++)
        begin
            r = rand_reg();
            issue_instr(enc_u(rand_bits(20), r, opc_lui));
            issue_instr(enc_i((rand_bits(10) << 2) | word_t'(1), r, 3'd0, rand_reg(), opc_jalr));
        end

        test_name = "memory";
        for (int i = 0; i < 12; i++)
        begin
            if (i % 2 == 1)
                issue_instr(enc_i(rand_bits(12), rand_reg(), 3'(rand_bits(3)), rand_reg(), opc_load));
            else
                issue_instr(enc_s(rand_bits(12), rand_reg(), rand_reg(), 3'(rand_bits(2))));
        end

        test_name = "unknown";
        issue_instr(32'h0000_000F);
        issue_instr(32'h0000_0073);

        test_name = "x0 write";
        issue_instr(enc_i(word_t'(77), reg_addr_t'(5), 3'd0, '0, opc_op_imm));
        issue_instr(enc_i('0, '0, 3'd0, reg_addr_t'(6), opc_op_imm));

        @(negedge clk);
        if (num_checked != num_instr)
            abort_run($sformatf("only %0d of %0d instructions retired", num_checked, num_instr));
        else
        begin
            $display("*** TEST PASSED ***");
            $finish;
        end
    end

endmodule

// File: design/rapid_core_top.sv
module rapid_core_top
(
    input  logic                 i_clk,
    input  logic                 i_reset,
    input  logic                 i_instr_req,
    input  rapid_pkg::word_t     i_instr,
    output logic                 o_instr_ack,
    output rapid_pkg::word_t     o_retire_pc,
    output logic                 o_rd_we,
    output rapid_pkg::reg_addr_t o_rd_addr,
    output rapid_pkg::word_t     o_rd_data,
    output rapid_pkg::word_t     o_next_pc
);

    // One instruction in flight on this bus
    stage_if stage_bus ();

    issue_control u_issue
    (
        .i_clk       (i_clk),
        .i_reset     (i_reset),
        .i_instr_req (i_instr_req),
        .i_instr     (i_instr),
        .o_instr_ack (o_instr_ack),
        .o_retire_pc (o_retire_pc),
        .o_rd_we     (o_rd_we),
        .o_rd_addr   (o_rd_addr),
        .o_rd_data   (o_rd_data),
        .o_next_pc   (o_next_pc),
        .stage       (stage_bus.issue)
    );

    decoder_logic u_decode
    (
        .stage (stage_bus.decode)
    );

    register_file u_regs
    (
        .i_clk   (i_clk),
        .i_reset (i_reset),
        .stage   (stage_bus.regs)
    );

    execute_unit u_exec
    (
        .stage (stage_bus.exec)
    );

endmodule

// File: design/issue_control.sv
`include "rapid_cfg.svh"

module issue_control
(
    input  logic                 i_clk,
    input  logic                 i_reset,
    input  logic                 i_instr_req,
    input  rapid_pkg::word_t     i_instr,
    output logic                 o_instr_ack,
    output rapid_pkg::word_t     o_retire_pc,
    output logic                 o_rd_we,
    output rapid_pkg::reg_addr_t o_rd_addr,
    output rapid_pkg::word_t     o_rd_data,
    output rapid_pkg::word_t     o_next_pc,
    stage_if.issue               stage
);
    import rapid_pkg::*;

    typedef enum logic [1:0] {st_idle, st_execute, st_ack} state_t;

    state_t    state_q;
    word_t     instr_q;
    word_t     pc_q;
    logic      ack_q;
    logic      rd_we_q;
    word_t     retire_pc_q;
    reg_addr_t rd_addr_q;
    word_t     rd_data_q;
    word_t     next_pc_q;

    //////////////////////////////////////////////////
    // Handshake FSM and program counter
    //////////////////////////////////////////////////

    always_ff @(posedge i_clk)
    begin
        if (i_reset)
        begin
            state_q <= st_idle;
            pc_q    <= `RAPID_RESET_PC;
            ack_q   <= 1'b0;
            rd_we_q <= 1'b0;
        end
        else
        begin
            case (state_q)
                st_idle:
                begin
                    if (i_instr_req)
                        state_q <= st_execute;
                end
                st_execute:
                begin
                    // Retire edge
                    state_q <= st_ack;
                    ack_q   <= 1'b1;
                    pc_q    <= stage.next_pc;
                    rd_we_q <= stage.wb_en;
                end
                st_ack:
                begin
                    // Held here under back-pressure
                    if (!i_instr_req)
                    begin
                        state_q <= st_idle;
                        ack_q   <= 1'b0;
                    end
                end
                default: state_q <= st_idle;
            endcase
        end
    end

    // Instruction register and retire record
    always_ff @(posedge i_clk)
    begin
        if (i_reset)
            instr_q <= '0;
        else if ((state_q == st_idle) && i_instr_req)
            instr_q <= i_instr;
        if (state_q == st_execute)
        begin
            retire_pc_q <= pc_q;
            rd_addr_q   <= stage.ctrl.rd;
            rd_data_q   <= stage.result;
            next_pc_q   <= stage.next_pc;
        end
    end

    assign stage.instr  = instr_q;
    assign stage.pc     = pc_q;
    assign stage.wr_stb = (state_q == st_execute);

    assign o_instr_ack = ack_q;
    assign o_retire_pc = retire_pc_q;
    assign o_rd_we     = rd_we_q;
    assign o_rd_addr   = rd_addr_q;
    assign o_rd_data   = rd_data_q;
    assign o_next_pc   = next_pc_q;

    ack_needs_req: assert property (@(posedge i_clk) disable iff (i_reset)
        $rose(ack_q) |-> $past(i_instr_req))
        else $error("ack rose without a pending request");

    pc_word_aligned: assert property (@(posedge i_clk) disable iff (i_reset)
        pc_q[1:0] == 2'b00)
        else $error("program counter lost word alignment");

endmodule

// File: design/execute_unit.sv
module execute_unit
(
    stage_if.exec stage
);
    import rapid_pkg::*;

    word_t      op_a;
    word_t      op_b;
    word_t      alu_res;
    word_t      pc_plus4;
    word_t      pc_imm;
    word_t      rs1_imm;
    logic [4:0] shamt;
    logic       branch_taken;

    assign op_a     = stage.rs1_val;
    assign op_b     = stage.ctrl.alu_reg ? stage.rs2_val : stage.imm;
    assign shamt    = op_b[4:0];
    assign pc_plus4 = stage.pc + word_t'(4);
    assign pc_imm   = stage.pc + stage.imm;
    assign rs1_imm  = op_a + stage.imm;

    //////////////////////////////////////////////////
    // ALU
    //////////////////////////////////////////////////

    always_comb
    begin
        case (stage.ctrl.fcs_opcode)
            f3_add:  alu_res = stage.ctrl.iop ? op_a - op_b : op_a + op_b;
            f3_sll:  alu_res = op_a << shamt;
            f3_slt:  alu_res = word_t'($signed(op_a) < $signed(op_b));
            f3_sltu: alu_res = word_t'(op_a < op_b);
            f3_xor:  alu_res = op_a ^ op_b;
            f3_sr:   alu_res = stage.ctrl.iop ? word_t'($signed(op_a) >>> shamt) : op_a >> shamt;
            f3_or:   alu_res = op_a | op_b;
            default: alu_res = op_a & op_b;
        endcase
    end

    // Branch compare always uses both registers
    always_comb
    begin
        case (stage.ctrl.fcs_opcode)
            3'b000:  branch_taken = (op_a == stage.rs2_val);
            3'b001:  branch_taken = (op_a != stage.rs2_val);
            3'b100:  branch_taken = ($signed(op_a) < $signed(stage.rs2_val));
            3'b101:  branch_taken = ($signed(op_a) >= $signed(stage.rs2_val));
            3'b110:  branch_taken = (op_a < stage.rs2_val);
            3'b111:  branch_taken = (op_a >= stage.rs2_val);
            default: branch_taken = 1'b0; // reserved encodings fall through
        endcase
    end

    //////////////////////////////////////////////////
    // Result, next PC and write-back select
    //////////////////////////////////////////////////

    always_comb
    begin
        stage.result  = '0;
        stage.next_pc = pc_plus4;
        stage.wb_en   = 1'b0;

        if (stage.ctrl.load_upper_imm)
        begin
            // LUI when iop, AUIPC otherwise
            stage.result = stage.ctrl.iop ? stage.imm : pc_imm;
            stage.wb_en  = 1'b1;
        end
        else if (stage.ctrl.uncond_branch)
        begin
            stage.result  = pc_plus4;
            stage.wb_en   = 1'b1;
            stage.next_pc = stage.ctrl.iop ? {rs1_imm[31:1], 1'b0} : pc_imm;
        end
        else if (stage.ctrl.cond_branch)
        begin
            stage.next_pc = branch_taken ? pc_imm : pc_plus4;
        end
        else if (stage.ctrl.mem)
        begin
            // No data memory, report the effective address
            stage.result = rs1_imm;
        end
        else if (stage.ctrl.alu_imm || stage.ctrl.alu_reg)
        begin
            stage.result = alu_res;
            stage.wb_en  = 1'b1;
        end
    end

endmodule

// File: design/register_file.sv
`include "rapid_cfg.svh"

module register_file
(
    input logic   i_clk,
    input logic   i_reset,
    stage_if.regs stage
);

    logic [`RAPID_XLEN-1:0] regs_q [`RAPID_NUM_REGS];
    logic                   wr_en;

    // x0 is never written, so its reset value stays
    assign wr_en = stage.wr_stb && stage.wb_en && (stage.ctrl.rd != '0);

    //////////////////////////////////////////////////
    // Write port
    //////////////////////////////////////////////////

    always_ff @(posedge i_clk)
    begin
        if (i_reset)
        begin
            for (int i = 0; i < `RAPID_NUM_REGS; i++)
            begin
                regs_q[i] <= '0;
            end
        end
        else if (wr_en)
        begin
            regs_q[stage.ctrl.rd] <= stage.result;
        end
    end

    //////////////////////////////////////////////////
    // Read ports
    //////////////////////////////////////////////////

    assign stage.rs1_val = regs_q[stage.ctrl.rs1];
    assign stage.rs2_val = regs_q[stage.ctrl.rs2];

    // x0 reads zero on both ports
    x0_reads_zero: assert property (@(posedge i_clk) disable iff (i_reset)
        ((stage.ctrl.rs1 != '0) || (stage.rs1_val == '0)) &&
        ((stage.ctrl.rs2 != '0) || (stage.rs2_val == '0)))
        else $error("x0 read back a nonzero value");

endmodule

// File: design/decoder_logic.sv
module decoder_logic
(
    stage_if.decode stage
);
    import rapid_pkg::*;

    opcode_family_t family;
    control_ex_s    ctrl_d;
    word_t          imm_d;
    word_t          instr;

    assign instr  = stage.instr;
    assign family = opcode_family_t'(instr[6:2]);

    //////////////////////////////////////////////////
    // Block classification and immediates
    //////////////////////////////////////////////////

    always_comb
    begin
        // Register fields are decoded for every format
        ctrl_d.rd             = instr[11:7];
        ctrl_d.rs1            = instr[19:15];
        ctrl_d.rs2            = instr[24:20];
        ctrl_d.fcs_opcode     = instr[14:12];
        ctrl_d.load_upper_imm = 1'b0;
        ctrl_d.uncond_branch  = 1'b0;
        ctrl_d.cond_branch    = 1'b0;
        ctrl_d.mem            = 1'b0;
        ctrl_d.alu_imm        = 1'b0;
        ctrl_d.alu_reg        = 1'b0;
        ctrl_d.iop            = 1'b0;
        imm_d                 = '0;

        case (family)
            op_upper, op_upper_pc:
            begin
                // iop marks LUI
                ctrl_d.load_upper_imm = 1'b1;
                ctrl_d.iop            = instr[5];
                imm_d                 = {instr[31:12], 12'b0};
            end

            op_jal, op_jalr:
            begin
                // iop marks JALR
                ctrl_d.uncond_branch = 1'b1;
                ctrl_d.iop           = !instr[3];
                if (instr[3])
                    imm_d = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
                else
                    imm_d = {{20{instr[31]}}, instr[31:20]};
            end

            op_branch:
            begin
                ctrl_d.cond_branch = 1'b1;
                imm_d = {{19{instr[31]}}, instr[31], instr[7], instr[30:25],
                         instr[11:8], 1'b0};
            end

            op_load, op_store:
            begin
                // Loads carry iop, stores use the split S immediate
                ctrl_d.mem = 1'b1;
                ctrl_d.iop = !instr[5];
                if (instr[5])
                    imm_d = {{20{instr[31]}}, instr[31:25], instr[11:7]};
                else
                    imm_d = {{20{instr[31]}}, instr[31:20]};
            end

            op_alu_imm, op_alu_reg:
            begin
                ctrl_d.alu_imm = !instr[5];
                ctrl_d.alu_reg = instr[5];
                // SUB and SRA on registers, only SRAI on immediates
                if (instr[5])
                    ctrl_d.iop = instr[30];
                else
                    ctrl_d.iop = instr[30] && (instr[14:12] == f3_sr);
                imm_d = {{20{instr[31]}}, instr[31:20]};
            end

            default:
            begin
                // Unknown opcode retires as a no-op
                imm_d = '0;
            end
        endcase
    end

    assign stage.ctrl = ctrl_d;
    assign stage.imm  = imm_d;

    always_comb
    begin
        one_block_flag: assert final ($onehot0({ctrl_d.load_upper_imm, ctrl_d.uncond_branch,
                                                ctrl_d.cond_branch, ctrl_d.mem,
                                                ctrl_d.alu_imm, ctrl_d.alu_reg}))
            else $error("decoder raised more than one block flag");
    end

endmodule

// File: design/stage_if.sv
interface stage_if;
    import rapid_pkg::*;

    word_t       instr;
    word_t       pc;
    control_ex_s ctrl;
    word_t       imm;
    word_t       rs1_val;
    word_t       rs2_val;
    word_t       result;
    word_t       next_pc;
    logic        wb_en;
    logic        wr_stb;

    // Issue owns the instruction, PC and write strobe
    modport issue  (output instr, output pc, output wr_stb,
                    input ctrl, input result, input next_pc, input wb_en);
    modport decode (input instr, output ctrl, output imm);
    modport regs   (input ctrl, input result, input wb_en, input wr_stb,
                    output rs1_val, output rs2_val);
    modport exec   (input ctrl, input imm, input pc, input rs1_val, input rs2_val,
                    output result, output next_pc, output wb_en);

endinterface

// File: design/rapid_pkg.sv
`include "rapid_cfg.svh"

package rapid_pkg;

    //////////////////////////////////////////////////
    // Basic types
    //////////////////////////////////////////////////

    typedef logic [`RAPID_XLEN-1:0] word_t;
    typedef logic [$clog2(`RAPID_NUM_REGS)-1:0] reg_addr_t;

    // Instruction word bits 6..2
    typedef enum logic [4:0] {
        op_upper    = 5'b01101, // LUI
        op_upper_pc = 5'b00101, // AUIPC
        op_jal      = 5'b11011,
        op_jalr     = 5'b11001,
        op_branch   = 5'b11000,
        op_load     = 5'b00000,
        op_store    = 5'b01000,
        op_alu_imm  = 5'b00100,
        op_alu_reg  = 5'b01100
    } opcode_family_t;

    // funct3 encodings for the ALU
    localparam logic [2:0] f3_add  = 3'b000;
    localparam logic [2:0] f3_sll  = 3'b001;
    localparam logic [2:0] f3_slt  = 3'b010;
    localparam logic [2:0] f3_sltu = 3'b011;
    localparam logic [2:0] f3_xor  = 3'b100;
    localparam logic [2:0] f3_sr   = 3'b101;
    localparam logic [2:0] f3_or   = 3'b110;
    localparam logic [2:0] f3_and  = 3'b111;

    //////////////////////////////////////////////////
    // Decoded control
    //////////////////////////////////////////////////

    // One block flag selects the unit, fcs_opcode the operation inside it
    typedef struct packed {
        reg_addr_t  rd;
        reg_addr_t  rs1;
        reg_addr_t  rs2;
        logic       load_upper_imm;
        logic       uncond_branch;
        logic       cond_branch;
        logic       mem;
        logic       alu_imm;
        logic       alu_reg;
        logic       iop;
        logic [2:0] fcs_opcode;
    } control_ex_s;

endpackage

// File: include/rapid_cfg.svh
`ifndef RAPID_CFG_SVH
`define RAPID_CFG_SVH

//////////////////////////////////////////////////
// Core sizing
//////////////////////////////////////////////////

// Data and address width
`define RAPID_XLEN 32

// Architectural registers, x0 included
`define RAPID_NUM_REGS 32

//////////////////////////////////////////////////
// Reset state
//////////////////////////////////////////////////

// First fetch address after reset
`define RAPID_RESET_PC 32'h0000_0000

`endif
